//--- build.f
+incdir+common
+incdir+verif
common/pcs_pkg.sv
pcs_tx/tx_classifier.sv
pcs_tx/encoder_fsm.sv
pcs_tx/tx_scrambler.sv
hw/pcs_tx_top.sv
verif/tb_pcs_tx.sv

//--- common/pcs_cfg.svh
`ifndef PCS_CFG_SVH
`define PCS_CFG_SVH

`define PCS_DATA_W    64
`define PCS_CTRL_W    8                 // One flag per lane
`define PCS_BLOCK_W   66

// Scrambler polynomial x^58 + x^39 + 1
`define PCS_SCR_W     58
`define PCS_SCR_SEED  {`PCS_SCR_W{1'b1}}

// XGMII control characters
`define PCS_CH_IDLE   8'h07
`define PCS_CH_START  8'hFB
`define PCS_CH_TERM   8'hFD
`define PCS_CH_ERROR  8'hFE

`define PCS_PCS_ERROR 7'h1E

`define PCS_SYNC_DATA 2'b01
`define PCS_SYNC_CTRL 2'b10
`define PCS_BT_CTRL   8'h1E             // All-control block type
`define PCS_ERROR_PAYLOAD {{8{`PCS_PCS_ERROR}}, `PCS_BT_CTRL}

`endif

//--- common/pcs_pkg.sv
`default_nettype none

`include "pcs_cfg.svh"

package pcs_pkg;

  typedef logic [`PCS_DATA_W-1:0] xgmii_data_t;
  typedef logic [`PCS_CTRL_W-1:0] xgmii_ctrl_t;

  // 01 data, 10 control
  typedef logic [1:0] sync_hdr_t;

  typedef logic [`PCS_BLOCK_W-3:0] block_payload_t;

  typedef struct packed {
    xgmii_data_t data;
    xgmii_ctrl_t ctrl;
  } xgmii_word_t;

  typedef struct packed {
    sync_hdr_t      hdr;
    block_payload_t payload;
  } coded_block_t;

  typedef enum logic [2:0] {
    TYPE_D,
    TYPE_S,
    TYPE_C,
    TYPE_T,
    TYPE_E
  } block_type_t;

  typedef struct packed {
    coded_block_t block;
    block_type_t  btype;
  } typed_block_t;

  // Transmit sequence states
  typedef enum logic [2:0] {
    TX_INIT,
    TX_C,
    TX_D,
    TX_T,
    TX_E
  } tx_state_t;

endpackage

`default_nettype wire

//--- hw/pcs_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_top
(
  input  wire                           i_clock,
  input  wire                           i_reset,
  input  wire                           i_valid,
  input  wire pcs_pkg::xgmii_word_t     i_word,
  output logic                          o_valid,
  output pcs_pkg::coded_block_t         o_block
);

  // Classifier to FSM
  logic                     cls_valid;
  pcs_pkg::typed_block_t    cls_typed;

  // FSM to scrambler
  logic                     enc_valid;
  pcs_pkg::coded_block_t    enc_block;

  tx_classifier u_classifier
  (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .i_word  (i_word),
    .o_valid (cls_valid),
    .o_typed (cls_typed)
  );

  encoder_fsm u_encoder
  (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_valid (cls_valid),
    .i_typed (cls_typed),
    .o_valid (enc_valid),
    .o_block (enc_block)
  );

  tx_scrambler u_scrambler
  (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_valid (enc_valid),
    .i_block (enc_block),
    .o_valid (o_valid),
    .o_block (o_block)
  );

endmodule

`default_nettype wire

//--- pcs_tx/encoder_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_cfg.svh"

module encoder_fsm
(
  input  wire                           i_clock,
  input  wire                           i_reset,
  input  wire                           i_valid,
  input  wire pcs_pkg::typed_block_t    i_typed,
  output logic                          o_valid,
  output pcs_pkg::coded_block_t         o_block
);

  // Local fault ordered set with seq 0x9C and data 00 00 01
  localparam pcs_pkg::coded_block_t LF_BLOCK = {`PCS_SYNC_CTRL, 64'h0000_0000_0100_004B};
  localparam pcs_pkg::coded_block_t ERR_BLOCK = {`PCS_SYNC_CTRL, `PCS_ERROR_PAYLOAD};

  pcs_pkg::tx_state_t     state;
  pcs_pkg::tx_state_t     state_next;
  pcs_pkg::block_type_t   btype;
  logic                   legal;
  pcs_pkg::coded_block_t  block_next;

  assign btype = i_typed.btype;

  always_comb
  begin
    state_next = pcs_pkg::TX_E;
    legal      = 1'b0;
    case (state)
      pcs_pkg::TX_INIT, pcs_pkg::TX_C, pcs_pkg::TX_T:
      begin
        if (btype == pcs_pkg::TYPE_C)
        begin
          legal      = 1'b1;
          state_next = pcs_pkg::TX_C;
        end
        else if (btype == pcs_pkg::TYPE_S)
        begin
          legal      = 1'b1;
          state_next = pcs_pkg::TX_D;
        end
      end
      pcs_pkg::TX_D:
      begin
        if (btype == pcs_pkg::TYPE_D)
        begin
          legal      = 1'b1;
          state_next = pcs_pkg::TX_D;
        end
        else if (btype == pcs_pkg::TYPE_T)
        begin
          legal      = 1'b1;
          state_next = pcs_pkg::TX_T;
        end
      end
      pcs_pkg::TX_E:
      begin
        // Resync on anything but start or error
        if (btype == pcs_pkg::TYPE_T)
        begin
          legal      = 1'b1;
          state_next = pcs_pkg::TX_T;
        end
        else if (btype == pcs_pkg::TYPE_D)
        begin
          legal      = 1'b1;
          state_next = pcs_pkg::TX_D;
        end
        else if (btype == pcs_pkg::TYPE_C)
        begin
          legal      = 1'b1;
          state_next = pcs_pkg::TX_C;
        end
      end
      default: state_next = pcs_pkg::TX_E;
    endcase
  end

  assign block_next = legal ? i_typed.block : ERR_BLOCK;

  always_ff @(posedge i_clock)
  begin
    if (i_reset)
    begin
      state   <= pcs_pkg::TX_INIT;
      o_block <= LF_BLOCK;
      o_valid <= 1'b0;
    end
    else
    begin
      o_valid <= i_valid;
      if (i_valid)
      begin
        state   <= state_next;
        o_block <= block_next;
      end
    end
  end

endmodule

`default_nettype wire

//--- pcs_tx/tx_classifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_cfg.svh"

module tx_classifier
(
  input  wire                           i_clock,
  input  wire                           i_reset,
  input  wire                           i_valid,
  input  wire pcs_pkg::xgmii_word_t     i_word,
  output logic                          o_valid,
  output pcs_pkg::typed_block_t         o_typed
);

  localparam logic [7:0] BT_START = 8'h78;

  pcs_pkg::xgmii_data_t     data;
  pcs_pkg::xgmii_ctrl_t     ctrl;
  pcs_pkg::xgmii_ctrl_t     lane_idle;
  pcs_pkg::xgmii_ctrl_t     lane_term;
  logic                     term_ok;
  logic [2:0]               term_lane;
  logic [7:0]               term_bt;
  pcs_pkg::block_payload_t  term_payload;
  pcs_pkg::block_type_t     btype;
  pcs_pkg::coded_block_t    block;

  assign data = i_word.data;
  assign ctrl = i_word.ctrl;

  always_comb
  begin
    for (int lane = 0; lane < `PCS_CTRL_W; lane++)
    begin
      lane_idle[lane] = ctrl[lane] && (data[8*lane +: 8] == `PCS_CH_IDLE);
      lane_term[lane] = ctrl[lane] && (data[8*lane +: 8] == `PCS_CH_TERM);
    end
  end

  // First control lane must be terminate with idles above it
  always_comb
  begin
    logic [`PCS_CTRL_W-1:0] low_mask;
    logic [`PCS_CTRL_W-1:0] high_mask;
    term_ok   = 1'b0;
    term_lane = '0;
    for (int k = 0; k < `PCS_CTRL_W; k++)
    begin
      low_mask  = (`PCS_CTRL_W'(1) << k) - `PCS_CTRL_W'(1);
      high_mask = ~(low_mask | (`PCS_CTRL_W'(1) << k));
      if (((ctrl & low_mask) == '0) && lane_term[k] &&
          ((lane_idle & high_mask) == high_mask))
      begin
        term_ok   = 1'b1;
        term_lane = 3'(k);
      end
    end
  end

  always_comb
  begin
    case (term_lane)
      3'd0: term_bt = 8'h87;
      3'd1: term_bt = 8'h99;
      3'd2: term_bt = 8'hAA;
      3'd3: term_bt = 8'hB4;
      3'd4: term_bt = 8'hCC;
      3'd5: term_bt = 8'hD2;
      3'd6: term_bt = 8'hE1;
      default: term_bt = 8'hFF;
    endcase
  end

  // Keep data bytes below the terminate lane
  assign term_payload = ((data & ({`PCS_DATA_W{1'b1}} >> (`PCS_DATA_W - 8*term_lane))) << 8)
                        | pcs_pkg::block_payload_t'(term_bt);

  always_comb
  begin
    block.hdr     = `PCS_SYNC_CTRL;
    block.payload = `PCS_ERROR_PAYLOAD;
    btype         = pcs_pkg::TYPE_E;
    if (ctrl == '0)
    begin
      btype         = pcs_pkg::TYPE_D;
      block.hdr     = `PCS_SYNC_DATA;
      block.payload = data;
    end
    else if ((ctrl == '1) && (lane_idle == '1))
    begin
      btype         = pcs_pkg::TYPE_C;
      block.payload = pcs_pkg::block_payload_t'(`PCS_BT_CTRL);  // Idle codes are zero
    end
    else if ((ctrl == `PCS_CTRL_W'(1)) && (data[7:0] == `PCS_CH_START))
    begin
      btype         = pcs_pkg::TYPE_S;
      block.payload = {data[`PCS_DATA_W-1:8], BT_START};
    end
    else if (term_ok)
    begin
      btype         = pcs_pkg::TYPE_T;
      block.payload = term_payload;
    end
  end

  always_ff @(posedge i_clock)
  begin
    if (i_reset)
      o_valid <= 1'b0;
    else
      o_valid <= i_valid;
  end

  always_ff @(posedge i_clock)
  begin
    if (i_valid)
    begin
      o_typed.block <= block;
      o_typed.btype <= btype;
    end
  end

endmodule

`default_nettype wire

//--- pcs_tx/tx_scrambler.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_cfg.svh"

module tx_scrambler
(
  input  wire                           i_clock,
  input  wire                           i_reset,
  input  wire                           i_valid,
  input  wire pcs_pkg::coded_block_t    i_block,
  output logic                          o_valid,
  output pcs_pkg::coded_block_t         o_block
);

  localparam int TAP_39 = 38;
  localparam int TAP_58 = `PCS_SCR_W - 1;

  logic [`PCS_SCR_W-1:0]    scr_state;
  logic [`PCS_SCR_W-1:0]    scr_next;
  pcs_pkg::block_payload_t  scrambled;

  // Bit 0 first and each output bit feeds back
  always_comb
  begin
    scr_next = scr_state;
    for (int i = 0; i < `PCS_DATA_W; i++)
    begin
      scrambled[i] = i_block.payload[i] ^ scr_next[TAP_39] ^ scr_next[TAP_58];
      scr_next     = {scr_next[`PCS_SCR_W-2:0], scrambled[i]};
    end
  end

  always_ff @(posedge i_clock)
  begin
    if (i_reset)
    begin
      o_valid   <= 1'b0;
      scr_state <= `PCS_SCR_SEED;
    end
    else
    begin
      o_valid <= i_valid;
      if (i_valid)
        scr_state <= scr_next;
    end
  end

  always_ff @(posedge i_clock)
  begin
    if (i_valid)
      o_block <= {i_block.hdr, scrambled};  // Header unscrambled
  end

endmodule

`default_nettype wire

//--- verif/tb_pcs_ref.svh
`ifndef TB_PCS_REF_SVH
`define TB_PCS_REF_SVH

// Terminate block types for k = 0..7 with one byte per position
localparam logic [63:0] REF_TERM_TYPES = 64'hFF_E1_D2_CC_B4_AA_99_87;

function automatic pcs_pkg::coded_block_t error_block();
  return {2'b10, {8{`PCS_PCS_ERROR}}, 8'h1E};
endfunction

function automatic pcs_pkg::typed_block_t classify_word(input pcs_pkg::xgmii_word_t w);
  pcs_pkg::typed_block_t r;
  int                    k;
  logic                  tail_idle;
  r.btype = pcs_pkg::TYPE_E;
  r.block = error_block();
  k = 0;
  while ((k < 8) && !w.ctrl[k])
    k++;                                // First control lane
  tail_idle = 1'b1;
  for (int j = k + 1; j < 8; j++)
    if (!w.ctrl[j] || (w.data[8*j +: 8] != `PCS_CH_IDLE))
      tail_idle = 1'b0;
  if (w.ctrl == 8'h00)
  begin
    r.btype = pcs_pkg::TYPE_D;
    r.block = {2'b01, w.data};
  end
  else if ((w.ctrl == 8'hFF) && (w.data == {8{`PCS_CH_IDLE}}))
  begin
    r.btype = pcs_pkg::TYPE_C;
    r.block = {2'b10, 56'h0, 8'h1E};
  end
  else if ((w.ctrl == 8'h01) && (w.data[7:0] == `PCS_CH_START))
  begin
    r.btype = pcs_pkg::TYPE_S;
    r.block = {2'b10, w.data[63:8], 8'h78};
  end
  else if ((k < 8) && (w.data[8*k +: 8] == `PCS_CH_TERM) && tail_idle)
  begin
    r.btype = pcs_pkg::TYPE_T;
    r.block = {2'b10, 64'h0};
    for (int j = 0; j < k; j++)
      r.block.payload[8*j+8 +: 8] = w.data[8*j +: 8];
    r.block.payload[7:0] = REF_TERM_TYPES[8*k +: 8];
  end
  return r;
endfunction

// TX_E on any illegal block type
function automatic pcs_pkg::tx_state_t next_tx_state(input pcs_pkg::tx_state_t s,
                                                     input pcs_pkg::block_type_t t);
  case (s)
    pcs_pkg::TX_INIT, pcs_pkg::TX_C, pcs_pkg::TX_T:
    begin
      if (t == pcs_pkg::TYPE_C)
        return pcs_pkg::TX_C;
      if (t == pcs_pkg::TYPE_S)
        return pcs_pkg::TX_D;
    end
    pcs_pkg::TX_D:
    begin
      if (t == pcs_pkg::TYPE_D)
        return pcs_pkg::TX_D;
      if (t == pcs_pkg::TYPE_T)
        return pcs_pkg::TX_T;
    end
    pcs_pkg::TX_E:
    begin
      if (t == pcs_pkg::TYPE_T)
        return pcs_pkg::TX_T;
      if (t == pcs_pkg::TYPE_D)
        return pcs_pkg::TX_D;
      if (t == pcs_pkg::TYPE_C)
        return pcs_pkg::TX_C;
    end
    default: ;
  endcase
  return pcs_pkg::TX_E;
endfunction

function automatic logic [63:0] scramble_payload(input logic [`PCS_SCR_W-1:0] st,
                                                 input logic [63:0] p);
  logic [63:0] o;
  for (int i = 0; i < 64; i++)
  begin
    o[i] = p[i] ^ st[38] ^ st[57];
    st   = {st[56:0], o[i]};
  end
  return o;
endfunction

// State holds the last 58 output bits with the newest in bit 0
function automatic logic [`PCS_SCR_W-1:0] scrambler_state_after(input logic [63:0] o);
  logic [`PCS_SCR_W-1:0] s;
  for (int j = 0; j < `PCS_SCR_W; j++)
    s[j] = o[63-j];
  return s;
endfunction

`endif

//--- verif/tb_pcs_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_cfg.svh"

module tb_pcs_tx;

  `include "tb_pcs_ref.svh"

  // Reset plus all tests and their drains rounded up
  localparam int STIM_CYCLES    = 640;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

  logic                   i_clock;
  logic                   i_reset;
  logic                   i_valid;
  pcs_pkg::xgmii_word_t   i_word;
  logic                   o_valid;
  pcs_pkg::coded_block_t  o_block;

  pcs_pkg::tx_state_t     model_state;
  logic [`PCS_SCR_W-1:0]  model_scr;
  pcs_pkg::coded_block_t  exp_q[$];
  string                  name_q[$];
  string                  test_name;
  pcs_pkg::coded_block_t  exp_block;
  string                  exp_name;
  logic [2:0]             valid_hist;   // i_valid seen 1..3 negedges ago
  int                     checks;
  int                     errors;
  int                     tests;
  int                     test_checks;
  int                     test_errors;
  int                     cycle_count;

  pcs_tx_top UUT
  (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .i_word  (i_word),
    .o_valid (o_valid),
    .o_block (o_block)
  );

  always #10 i_clock = ~i_clock;

  function automatic logic [63:0] random_data();
    return {$urandom, $urandom};
  endfunction

  function automatic pcs_pkg::xgmii_word_t idle_word();
    pcs_pkg::xgmii_word_t w;
    w.data = {8{`PCS_CH_IDLE}};
    w.ctrl = 8'hFF;
    return w;
  endfunction

  function automatic pcs_pkg::xgmii_word_t data_word();
    pcs_pkg::xgmii_word_t w;
    w.data = random_data();
    w.ctrl = 8'h00;
    return w;
  endfunction

  function automatic pcs_pkg::xgmii_word_t start_word();
    pcs_pkg::xgmii_word_t w;
    w.data      = random_data();
    w.data[7:0] = `PCS_CH_START;
    w.ctrl      = 8'h01;
    return w;
  endfunction

  function automatic pcs_pkg::xgmii_word_t term_word(input int k);
    pcs_pkg::xgmii_word_t w;
    w = idle_word();
    for (int j = 0; j < k; j++)
    begin
      w.data[8*j +: 8] = 8'($urandom);
      w.ctrl[j]        = 1'b0;
    end
    w.data[8*k +: 8] = `PCS_CH_TERM;
    return w;
  endfunction

  function automatic pcs_pkg::xgmii_word_t error_word();
    pcs_pkg::xgmii_word_t w;
    int                   lane;
    w    = idle_word();
    lane = $urandom_range(7, 0);
    w.data[8*lane +: 8] = `PCS_CH_ERROR;
    return w;
  endfunction

  function automatic pcs_pkg::xgmii_word_t random_word();
    case ($urandom_range(4, 0))
      0: return idle_word();
      1: return start_word();
      2: return data_word();
      3: return term_word($urandom_range(7, 0));
      default: return error_word();
    endcase
  endfunction

  // Drive one valid word and queue its expected block
  task automatic send_word(input pcs_pkg::xgmii_word_t w);
    pcs_pkg::typed_block_t typed;
    pcs_pkg::coded_block_t exp;
    @(posedge i_clock);
    #2;
    i_valid     = 1'b1;
    i_word      = w;
    typed       = classify_word(w);
    model_state = next_tx_state(model_state, typed.btype);
    exp         = (model_state == pcs_pkg::TX_E) ? error_block() : typed.block;
    exp.payload = scramble_payload(model_scr, exp.payload);
    model_scr   = scrambler_state_after(exp.payload);
    exp_q.push_back(exp);
    name_q.push_back(test_name);
  endtask

  task automatic bubble();
    @(posedge i_clock);
    #2;
    i_valid = 1'b0;
    i_word  = {random_data(), 8'($urandom)};   // Junk must be ignored
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test();
    bubble();
    while (exp_q.size() != 0)
      @(negedge i_clock);
    @(negedge i_clock);
    tests++;
    $display("%s done: %0d blocks checked, %0d errors", test_name,
             checks - test_checks, errors - test_errors);
  endtask

  // Outputs are sampled mid-cycle
  always @(negedge i_clock)
  begin
    if (!i_reset)
    begin
      if (o_valid !== valid_hist[2])
      begin
        errors++;
        $display("In %s o_valid did not follow i_valid by three cycles", test_name);
      end
      if (o_valid === 1'b1)
      begin
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("In %s an output block arrived with none expected", test_name);
        end
        else
        begin
          exp_block = exp_q.pop_front();
          exp_name  = name_q.pop_front();
          checks++;
          if (o_block !== exp_block)
          begin
            errors++;
            $display("Mismatch in %s: expected %h, actual %h", exp_name, exp_block, o_block);
          end
        end
      end
    end
    valid_hist = {valid_hist[1:0], i_valid};
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge i_clock);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles, expected blocks never arrived", cycle_count);
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    i_clock     = 1'b0;
    i_reset     = 1'b1;
    i_valid     = 1'b0;
    i_word      = '0;
    valid_hist  = '0;
    checks      = 0;
    errors      = 0;
    tests       = 0;
    test_name   = "reset";
    model_state = pcs_pkg::TX_INIT;
    model_scr   = `PCS_SCR_SEED;
    void'($urandom(29050));
    repeat (10) @(posedge i_clock);
    #2;
    i_reset = 1'b0;

    start_test("idle_stream");
    repeat (16) send_word(idle_word());
    end_test();

    start_test("legal_frames");
    for (int k = 0; k < 8; k++)
    begin
      repeat (2 + $urandom_range(2, 0)) send_word(idle_word());
      send_word(start_word());
      repeat (1 + $urandom_range(5, 0)) send_word(data_word());
      send_word(term_word(k));
      if (model_state != pcs_pkg::TX_T)
      begin
        errors++;
        $display("Frame ending in lane %0d was not accepted as a legal terminate", k);
      end
    end
    end_test();

    start_test("illegal_sequence");
    send_word(idle_word());
    send_word(data_word());             // Data after idle
    send_word(idle_word());
    send_word(start_word());
    send_word(data_word());
    send_word(start_word());            // Start inside a frame
    send_word(term_word(3));
    send_word(error_word());
    send_word(idle_word());
    end_test();

    start_test("recovery");
    send_word(error_word());
    send_word(data_word());
    send_word(data_word());
    send_word(term_word(5));
    send_word(error_word());
    send_word(term_word(0));
    send_word(error_word());
    send_word(idle_word());
    send_word(error_word());
    send_word(start_word());            // Still illegal from TX_E
    send_word(idle_word());
    end_test();

    start_test("valid_gaps");
    repeat (40)
    begin
      repeat ($urandom_range(2, 0)) bubble();
      send_word(random_word());
    end
    end_test();

    start_test("random_mix");
    repeat (300) send_word(random_word());
    end_test();

    $display("%0d tests, %0d blocks checked, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire
